/* sources.f */
bridge_pkg.sv
skid_buf.sv
id_fifo.sv
axi_axil_reflect_wr.sv
axil_reg_bank.sv
axi_wr_bridge_top.sv
tb_axi_wr_bridge_chk.sv
tb_axi_wr_bridge.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f sources.f --top-module tb_axi_wr_bridge
out=$(./obj_dir/Vtb_axi_wr_bridge +verilator+error+limit+100)
echo "$out"
echo "$out" | grep -q "TESTBENCH PASSED"

/* tb_axi_wr_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_axi_wr_bridge;

  import bridge_pkg::*;

  localparam int N_RAND = 40;
  localparam int N_ERR = 12;
  localparam int N_BP = 10;
  localparam int N_TOTAL = N_RAND + N_ERR + N_BP;
  localparam logic [31:0] SEED = 32'h40fc_46cf;

  logic                 clk;
  logic                 i_arst_n;
  logic                 i_s_awvalid;
  addr_t                i_s_awaddr;
  id_t                  i_s_awid;
  user_t                i_s_awuser;
  logic                 o_s_awready;
  logic                 i_s_wvalid;
  data_t                i_s_wdata;
  strb_t                i_s_wstrb;
  logic                 o_s_wready;
  logic                 o_s_bvalid;
  id_t                  o_s_bid;
  resp_t                o_s_bresp;
  user_t                o_s_buser;
  logic                 i_s_bready;
  logic [REG_IDX_W-1:0] i_peek_idx;
  data_t                o_peek_data;

  logic [31:0]          rng;
  logic [31:0]          rng_b;
  int                   issued;
  int                   answered;
  int                   tests;
  int                   stall_pct;
  logic                 hold_low;
  logic [REG_IDX_W-1:0] sweep_idx;
  addr_t                addr_q [$];

  axi_wr_bridge_top dut_i (.*);

  bind axi_wr_bridge_top tb_axi_wr_bridge_chk chk_i (.*);

  always #2 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [REG_IDX_W-1:0] reg_of(input addr_t a);
    addr_t w;
    w = a / addr_t'(STRB_W);
    return w[REG_IDX_W-1:0];
  endfunction

  // Random bready stalls and a peek index that follows the oldest write
  always @(negedge clk) begin
    rng_b = xorshift(rng_b);
    i_s_bready = i_arst_n && !hold_low && ((rng_b % 100) >= stall_pct);
    if (addr_q.size() > 0) begin
      i_peek_idx = reg_of(addr_q[0]);
    end else begin
      i_peek_idx = sweep_idx;
    end
  end

  always @(posedge clk) begin
    if (i_arst_n && o_s_bvalid && i_s_bready) begin
      answered++;
      void'(addr_q.pop_front());
    end
  end

  task automatic write_one(input addr_t a);
    logic aw_done;
    logic w_done;
    rng = xorshift(rng);
    @(negedge clk);
    i_s_awvalid = 1'b1;
    i_s_awaddr  = a;
    i_s_awid    = rng[21:18];
    i_s_awuser  = rng[22];
    i_s_wvalid  = 1'b1;
    i_s_wdata   = rng[15:0];
    i_s_wstrb   = rng[17:16];
    aw_done     = 1'b0;
    w_done      = 1'b0;
    while (!(aw_done && w_done)) begin
      @(posedge clk);
      if (i_s_awvalid && o_s_awready) begin
        aw_done = 1'b1;
        issued++;
        addr_q.push_back(a);
      end
      if (i_s_wvalid && o_s_wready) begin
        w_done = 1'b1;
      end
      @(negedge clk);
      i_s_awvalid = !aw_done;
      i_s_wvalid  = !w_done;
    end
  endtask

  task automatic rand_write(input logic bad);
    rng = xorshift(rng);
    if (bad) begin
      write_one(8'd16 + (rng[7:0] % 8'd240));
    end else begin
      write_one({4'h0, rng[3:0]});
    end
  endtask

  task automatic drain();
    while (answered != issued) begin
      @(posedge clk);
    end
  endtask

  task automatic sweep_regs();
    for (int i = 0; i < NUM_REGS; i++) begin
      @(posedge clk);
      sweep_idx = i[REG_IDX_W-1:0];
    end
    // Last index is sampled on the next edge
    @(posedge clk);
    @(negedge clk);
  endtask

  task automatic report(input string name);
    tests++;
    $display("test %s done: %0d of %0d writes answered, %0d assertion failures",
             name, answered, issued, dut_i.chk_i.fail_cnt);
  endtask

  initial begin
    rng         = SEED;
    rng_b       = xorshift(SEED);
    clk         = 1'b0;
    i_arst_n    = 1'b0;
    i_s_awvalid = 1'b0;
    i_s_awaddr  = '0;
    i_s_awid    = '0;
    i_s_awuser  = '0;
    i_s_wvalid  = 1'b0;
    i_s_wdata   = '0;
    i_s_wstrb   = '0;
    i_s_bready  = 1'b0;
    i_peek_idx  = '0;
    sweep_idx   = '0;
    hold_low    = 1'b0;
    stall_pct   = 0;
    issued      = 0;
    answered    = 0;
    tests       = 0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    i_arst_n = 1'b1;
    sweep_regs();
    report("reset");
    stall_pct = 25;
    repeat (N_RAND) rand_write(1'b0);
    drain();
    report("random");
    for (int i = 0; i < N_ERR; i++) begin
      rand_write(i % 2 == 0);
    end
    drain();
    report("slverr");
    hold_low = 1'b1;
    fork
      repeat (N_BP) rand_write(1'b0);
      begin
        repeat (40) @(posedge clk);
        hold_low = 1'b0;
      end
    join
    drain();
    sweep_regs();
    report("backpressure");
    $display("tests %0d, writes %0d, responses %0d, assertion failures %0d",
             tests, issued, answered, dut_i.chk_i.fail_cnt);
    if (dut_i.chk_i.fail_cnt == 0 && answered == N_TOTAL) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial begin
    repeat (N_TOTAL * 20) @(posedge clk);
    $display("timeout: writes still waiting for a response after %0d cycles",
             N_TOTAL * 20);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* tb_axi_wr_bridge_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_axi_wr_bridge_chk (
  input logic                             clk,
  input logic                             i_arst_n,
  input logic                             i_s_awvalid,
  input bridge_pkg::addr_t                i_s_awaddr,
  input bridge_pkg::id_t                  i_s_awid,
  input bridge_pkg::user_t                i_s_awuser,
  input logic                             o_s_awready,
  input logic                             i_s_wvalid,
  input bridge_pkg::data_t                i_s_wdata,
  input bridge_pkg::strb_t                i_s_wstrb,
  input logic                             o_s_wready,
  input logic                             o_s_bvalid,
  input bridge_pkg::id_t                  o_s_bid,
  input bridge_pkg::resp_t                o_s_bresp,
  input bridge_pkg::user_t                o_s_buser,
  input logic                             i_s_bready,
  input logic [bridge_pkg::REG_IDX_W-1:0] i_peek_idx,
  input bridge_pkg::data_t                o_peek_data
);

  import bridge_pkg::*;

  localparam int QN = 16;

  int     fail_cnt = 0;
  idtag_t tag_q [QN];
  addr_t  addr_q [QN];
  wbeat_t w_q [QN];
  data_t  shadow [NUM_REGS];
  int     aw_wp;
  int     w_wp;
  int     rd_p;
  int     pending;
  logic   b_fire;
  idtag_t head_tag;
  addr_t  head_word;
  logic   head_in_range;
  data_t  exp_data;
  data_t  idle_exp;

  assign b_fire = o_s_bvalid && i_s_bready;

  // Expected register value once the oldest write lands
  always_comb begin
    pending       = aw_wp - rd_p;
    head_tag      = tag_q[rd_p % QN];
    head_word     = addr_q[rd_p % QN] / addr_t'(STRB_W);
    head_in_range = head_word < addr_t'(NUM_REGS);
    exp_data      = shadow[head_word[REG_IDX_W-1:0]];
    for (int b = 0; b < STRB_W; b++) begin
      if (w_q[rd_p % QN].strb[b]) begin
        exp_data[b*8 +: 8] = w_q[rd_p % QN].data[b*8 +: 8];
      end
    end
    idle_exp = shadow[i_peek_idx];
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      aw_wp <= 0;
      w_wp  <= 0;
      rd_p  <= 0;
      for (int r = 0; r < NUM_REGS; r++) begin
        shadow[r] <= '0;
      end
    end else begin
      if (i_s_awvalid && o_s_awready) begin
        tag_q[aw_wp % QN]  <= {i_s_awid, i_s_awuser};
        addr_q[aw_wp % QN] <= i_s_awaddr;
        aw_wp              <= aw_wp + 1;
      end
      if (i_s_wvalid && o_s_wready) begin
        w_q[w_wp % QN] <= {i_s_wstrb, i_s_wdata};
        w_wp           <= w_wp + 1;
      end
      if (b_fire) begin
        if (head_in_range) begin
          shadow[head_word[REG_IDX_W-1:0]] <= exp_data;
        end
        rd_p <= rd_p + 1;
      end
    end
  end

  a_reset_bvalid: assert property (@(posedge clk) !i_arst_n |-> !o_s_bvalid)
    else begin $error("error at %0t: bvalid high in reset", $time); fail_cnt++; end

  a_b_order: assert property (@(posedge clk) disable iff (!i_arst_n)
    b_fire |-> pending > 0 && o_s_bid == head_tag.id && o_s_buser == head_tag.user)
    else begin $error("error at %0t: B id/user out of order", $time); fail_cnt++; end

  a_resp: assert property (@(posedge clk) disable iff (!i_arst_n)
    b_fire |-> o_s_bresp == (head_in_range ? RESP_OKAY : RESP_SLVERR))
    else begin $error("error at %0t: wrong bresp", $time); fail_cnt++; end

  a_okay_data: assert property (@(posedge clk) disable iff (!i_arst_n)
    b_fire && head_in_range |->
      i_peek_idx == head_word[REG_IDX_W-1:0] && o_peek_data == exp_data)
    else begin $error("error at %0t: register value after write", $time); fail_cnt++; end

  // With nothing in flight every register matches the shadow
  a_idle_regs: assert property (@(posedge clk) disable iff (!i_arst_n)
    pending == 0 |-> o_peek_data == idle_exp)
    else begin $error("error at %0t: idle register mismatch", $time); fail_cnt++; end

  a_b_stable: assert property (@(posedge clk) disable iff (!i_arst_n)
    o_s_bvalid && !i_s_bready |=> o_s_bvalid && $stable(o_s_bid) &&
      $stable(o_s_bresp) && $stable(o_s_buser))
    else begin $error("error at %0t: B changed while stalled", $time); fail_cnt++; end

  // Two tags, two skid entries and one pending response
  a_outstanding: assert property (@(posedge clk) disable iff (!i_arst_n) pending <= 5)
    else begin $error("error at %0t: too many writes in flight", $time); fail_cnt++; end

endmodule

`default_nettype wire

/* axi_wr_bridge_top.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_wr_bridge_top (
  input  logic                              clk,
  input  logic                              i_arst_n,

  input  logic                              i_s_awvalid,
  input  bridge_pkg::addr_t                 i_s_awaddr,
  input  bridge_pkg::id_t                   i_s_awid,
  input  bridge_pkg::user_t                 i_s_awuser,
  output logic                              o_s_awready,
  input  logic                              i_s_wvalid,
  input  bridge_pkg::data_t                 i_s_wdata,
  input  bridge_pkg::strb_t                 i_s_wstrb,
  output logic                              o_s_wready,
  output logic                              o_s_bvalid,
  output bridge_pkg::id_t                   o_s_bid,
  output bridge_pkg::resp_t                 o_s_bresp,
  output bridge_pkg::user_t                 o_s_buser,
  input  logic                              i_s_bready,

  input  logic [bridge_pkg::REG_IDX_W-1:0]  i_peek_idx,
  output bridge_pkg::data_t                 o_peek_data
);

  import bridge_pkg::*;

  addr_t m_axil_awaddr;
  logic  m_axil_awvalid;
  logic  m_axil_awready;
  data_t m_axil_wdata;
  strb_t m_axil_wstrb;
  logic  m_axil_wvalid;
  logic  m_axil_wready;
  resp_t m_axil_bresp;
  logic  m_axil_bvalid;
  logic  m_axil_bready;

  axi_axil_reflect_wr reflect_i (
    .clk        (clk),
    .i_arst_n   (i_arst_n),
    .i_s_awvalid(i_s_awvalid),
    .i_s_awaddr (i_s_awaddr),
    .i_s_awid   (i_s_awid),
    .i_s_awuser (i_s_awuser),
    .o_s_awready(o_s_awready),
    .i_s_wvalid (i_s_wvalid),
    .i_s_wdata  (i_s_wdata),
    .i_s_wstrb  (i_s_wstrb),
    .o_s_wready (o_s_wready),
    .o_s_bvalid (o_s_bvalid),
    .o_s_bid    (o_s_bid),
    .o_s_bresp  (o_s_bresp),
    .o_s_buser  (o_s_buser),
    .i_s_bready (i_s_bready),
    .o_m_awaddr (m_axil_awaddr),
    .o_m_awvalid(m_axil_awvalid),
    .i_m_awready(m_axil_awready),
    .o_m_wdata  (m_axil_wdata),
    .o_m_wstrb  (m_axil_wstrb),
    .o_m_wvalid (m_axil_wvalid),
    .i_m_wready (m_axil_wready),
    .i_m_bresp  (m_axil_bresp),
    .i_m_bvalid (m_axil_bvalid),
    .o_m_bready (m_axil_bready)
  );

  axil_reg_bank reg_bank_i (
    .clk        (clk),
    .i_arst_n   (i_arst_n),
    .i_awaddr   (m_axil_awaddr),
    .i_awvalid  (m_axil_awvalid),
    .o_awready  (m_axil_awready),
    .i_wdata    (m_axil_wdata),
    .i_wstrb    (m_axil_wstrb),
    .i_wvalid   (m_axil_wvalid),
    .o_wready   (m_axil_wready),
    .o_bresp    (m_axil_bresp),
    .o_bvalid   (m_axil_bvalid),
    .i_bready   (m_axil_bready),
    .i_peek_idx (i_peek_idx),
    .o_peek_data(o_peek_data)
  );

endmodule

`default_nettype wire

/* axil_reg_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module axil_reg_bank (
  input  logic                                clk,
  input  logic                                i_arst_n,

  input  bridge_pkg::addr_t                   i_awaddr,
  input  logic                                i_awvalid,
  output logic                                o_awready,
  input  bridge_pkg::data_t                   i_wdata,
  input  bridge_pkg::strb_t                   i_wstrb,
  input  logic                                i_wvalid,
  output logic                                o_wready,
  output bridge_pkg::resp_t                   o_bresp,
  output logic                                o_bvalid,
  input  logic                                i_bready,

  input  logic [bridge_pkg::REG_IDX_W-1:0]    i_peek_idx,
  output bridge_pkg::data_t                   o_peek_data
);

  import bridge_pkg::*;

  logic                 wr_accept;
  logic                 in_range;
  addr_t                word_idx;
  logic [REG_IDX_W-1:0] reg_idx;

  data_t regs [NUM_REGS];

  // AW and W are taken together, one response at a time
  assign wr_accept = i_awvalid && i_wvalid && !o_bvalid;
  assign o_awready = wr_accept;
  assign o_wready  = wr_accept;

  assign word_idx = i_awaddr >> $clog2(STRB_W);
  assign in_range = word_idx < addr_t'(NUM_REGS);
  assign reg_idx  = word_idx[REG_IDX_W-1:0];

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int r = 0; r < NUM_REGS; r++) begin
        regs[r] <= '0;
      end
    end else if (wr_accept && in_range) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (i_wstrb[b]) begin
          regs[reg_idx][b*8 +: 8] <= i_wdata[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_bvalid <= 1'b0;
    end else if (wr_accept) begin
      o_bvalid <= 1'b1;
    end else if (i_bready) begin
      o_bvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_accept) begin
      o_bresp <= in_range ? RESP_OKAY : RESP_SLVERR;
    end
  end

  // Peek is combinational for the testbench
  assign o_peek_data = regs[i_peek_idx];

endmodule

`default_nettype wire

/* axi_axil_reflect_wr.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_axil_reflect_wr (
  input  logic               clk,
  input  logic               i_arst_n,

  input  logic               i_s_awvalid,
  input  bridge_pkg::addr_t  i_s_awaddr,
  input  bridge_pkg::id_t    i_s_awid,
  input  bridge_pkg::user_t  i_s_awuser,
  output logic               o_s_awready,
  input  logic               i_s_wvalid,
  input  bridge_pkg::data_t  i_s_wdata,
  input  bridge_pkg::strb_t  i_s_wstrb,
  output logic               o_s_wready,
  output logic               o_s_bvalid,
  output bridge_pkg::id_t    o_s_bid,
  output bridge_pkg::resp_t  o_s_bresp,
  output bridge_pkg::user_t  o_s_buser,
  input  logic               i_s_bready,

  output bridge_pkg::addr_t  o_m_awaddr,
  output logic               o_m_awvalid,
  input  logic               i_m_awready,
  output bridge_pkg::data_t  o_m_wdata,
  output bridge_pkg::strb_t  o_m_wstrb,
  output logic               o_m_wvalid,
  input  logic               i_m_wready,
  input  bridge_pkg::resp_t  i_m_bresp,
  input  logic               i_m_bvalid,
  output logic               o_m_bready
);

  import bridge_pkg::*;

  logic   aw_sb_ready;
  logic   w_sb_ready;
  logic   tag_full;
  wbeat_t s_wbeat;
  wbeat_t m_wbeat;
  idtag_t push_tag;
  idtag_t head_tag;

  assign s_wbeat.strb  = i_s_wstrb;
  assign s_wbeat.data  = i_s_wdata;
  assign push_tag.id   = i_s_awid;
  assign push_tag.user = i_s_awuser;

  skid_buf #(.T(addr_t)) aw_sb_i (
    .clk     (clk),
    .i_arst_n(i_arst_n),
    .i_valid (i_s_awvalid && o_s_awready),
    .i_data  (i_s_awaddr),
    .o_ready (aw_sb_ready),
    .o_valid (o_m_awvalid),
    .o_data  (o_m_awaddr),
    .i_ready (i_m_awready)
  );

  skid_buf #(.T(wbeat_t)) w_sb_i (
    .clk     (clk),
    .i_arst_n(i_arst_n),
    .i_valid (i_s_wvalid && o_s_wready),
    .i_data  (s_wbeat),
    .o_ready (w_sb_ready),
    .o_valid (o_m_wvalid),
    .o_data  (m_wbeat),
    .i_ready (i_m_wready)
  );

  // AXI-Lite has no IDs, so tags wait here for their B
  id_fifo #(.T(idtag_t)) tag_fifo_i (
    .clk     (clk),
    .i_arst_n(i_arst_n),
    .i_push  (i_s_awvalid && o_s_awready),
    .i_data  (push_tag),
    .o_full  (tag_full),
    .i_pop   (i_m_bvalid && i_s_bready),
    .o_data  (head_tag),
    .o_empty ()
  );

  assign o_s_awready = aw_sb_ready && !tag_full;
  assign o_s_wready  = w_sb_ready && !tag_full;

  assign o_m_wdata = m_wbeat.data;
  assign o_m_wstrb = m_wbeat.strb;

  assign o_s_bvalid = i_m_bvalid;
  assign o_s_bresp  = i_m_bresp;
  assign o_s_bid    = head_tag.id;
  assign o_s_buser  = head_tag.user;
  assign o_m_bready = i_s_bready;

endmodule

`default_nettype wire

/* id_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module id_fifo #(
  parameter type T = logic [7:0]
) (
  input  logic clk,
  input  logic i_arst_n,

  input  logic i_push,
  input  T     i_data,
  output logic o_full,

  input  logic i_pop,
  output T     o_data,
  output logic o_empty
);

  import bridge_pkg::*;

  // Extra top bit tells full from empty
  logic [OUTST_W:0] wr_ptr;
  logic [OUTST_W:0] rd_ptr;
  logic             do_push;
  logic             do_pop;

  T mem [FIFO_DEPTH];

  assign o_empty = (wr_ptr == rd_ptr);
  assign o_full  = (wr_ptr[OUTST_W] != rd_ptr[OUTST_W]) &&
                   (wr_ptr[OUTST_W-1:0] == rd_ptr[OUTST_W-1:0]);

  assign do_push = i_push && !o_full;
  assign do_pop  = i_pop && !o_empty;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr[OUTST_W-1:0]] <= i_data;
    end
  end

  // Head visible with no read latency
  assign o_data = mem[rd_ptr[OUTST_W-1:0]];

endmodule

`default_nettype wire

/* skid_buf.sv */
`timescale 1ns/1ps
`default_nettype none

module skid_buf #(
  parameter type T = logic [7:0]
) (
  input  logic clk,
  input  logic i_arst_n,

  input  logic i_valid,
  input  T     i_data,
  output logic o_ready,

  output logic o_valid,
  output T     o_data,
  input  logic i_ready
);

  logic in_fire;
  logic out_open;
  logic skid_valid;
  T     skid_data;

  // Ready comes from local state only, never from i_ready
  assign o_ready  = !skid_valid;
  assign in_fire  = i_valid && o_ready;
  assign out_open = !o_valid || i_ready;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_valid    <= 1'b0;
      skid_valid <= 1'b0;
    end else begin
      if (out_open) begin
        // Skid entry drains first, else take the new beat
        o_valid    <= skid_valid || in_fire;
        skid_valid <= 1'b0;
      end else if (in_fire) begin
        skid_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (out_open) begin
      if (skid_valid) begin
        o_data <= skid_data;
      end else if (in_fire) begin
        o_data <= i_data;
      end
    end else if (in_fire) begin
      // Output stalled, park the beat
      skid_data <= i_data;
    end
  end

endmodule

`default_nettype wire

/* bridge_pkg.sv */
`default_nettype none

package bridge_pkg;

  localparam int ADDR_W = 8;
  localparam int DATA_W = 16;
  localparam int STRB_W = DATA_W / 8;
  localparam int ID_W = 4;
  localparam int USER_W = 1;

  // Two outstanding writes
  localparam int OUTST_W = 1;
  localparam int FIFO_DEPTH = 1 << OUTST_W;

  localparam int NUM_REGS = 8;
  localparam int REG_IDX_W = 3;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;
  typedef logic [ID_W-1:0] id_t;
  typedef logic [USER_W-1:0] user_t;
  typedef logic [1:0] resp_t;

  typedef struct packed {
    strb_t strb;
    data_t data;
  } wbeat_t;

  typedef struct packed {
    id_t   id;
    user_t user;
  } idtag_t;

  localparam resp_t RESP_OKAY = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire
